//--- bench/cache_tag_properties.sv
// ========================================
// Concurrent checks on the response timing of the tag unit
// Attached to cache_tag_unit by a bind in the testbench
// ========================================
`timescale 1ns/1ps

module cache_tag_properties (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    cmd_valid,
   input  logic                    resp_valid,
   input  cache_pkg::cache_cmd_t   resp_cmd,
   input  logic                    resp_hit
);

   import cache_pkg::*;

   // ========================================
   // Response timing
   // ========================================
   // Every accepted command answers on the very next edge
   resp_follows_cmd: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_valid |=> resp_valid)
      else $error("resp_valid did not follow cmd_valid by one cycle");

   // No command means no response, so nothing shows up late or twice
   no_spurious_resp: assert property (@(posedge clk) disable iff (!rst_n)
      !cmd_valid |=> !resp_valid)
      else $error("resp_valid high without a command in the cycle before");

   // A fill only reports its victim, never a hit
   fill_never_hits: assert property (@(posedge clk) disable iff (!rst_n)
      (resp_valid && resp_cmd == CMD_FILL) |-> !resp_hit)
      else $error("resp_hit set on a fill response");

   // Synchronous reset clears the response at the edge that samples it
   quiet_in_reset: assert property (@(posedge clk)
      !rst_n |=> !resp_valid)
      else $error("resp_valid high after a reset edge");

endmodule

//--- bench/cache_tag_tb.sv
// ========================================
// Testbench for the cache tag unit that runs one command per cycle from the testdata file
// Each response is compared with the expected hit, way and physical tag
// ========================================
`timescale 1ns/1ps

module cache_tag_tb;

   import cache_pkg::*;

   localparam int    RESP_TIMEOUT = 10;  // Cycles allowed for one response
   localparam string DATA_FILE    = "bench/cache_tag_testdata.txt";

   logic        clk;
   logic        rst_n;
   logic        cmd_valid;
   cache_cmd_t  cmd;
   address_t    vadr;
   address_t    padr;
   logic        resp_valid;
   cache_cmd_t  resp_cmd;
   logic        resp_hit;
   way_t        resp_way;
   cache_tag_t  resp_ptag;

   int errors;  // Wrong values and other failures
   int checks;  // Responses compared

   cache_tag_unit i_cache_tag_unit (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_valid  (cmd_valid),
      .cmd        (cmd),
      .vadr       (vadr),
      .padr       (padr),
      .resp_valid (resp_valid),
      .resp_cmd   (resp_cmd),
      .resp_hit   (resp_hit),
      .resp_way   (resp_way),
      .resp_ptag  (resp_ptag)
   );

   bind cache_tag_unit cache_tag_properties i_cache_tag_properties (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_valid  (cmd_valid),
      .resp_valid (resp_valid),
      .resp_cmd   (resp_cmd),
      .resp_hit   (resp_hit)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;  // 4 ns period

   // ========================================
   // Helpers
   // ========================================
   task automatic report_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
      $display("Fail %s %s: expected %0h, actual %0h", name, field, expected, actual);
      errors++;
   endtask

   // Steps to the edge after the command and counts extra edges until a response shows up
   task automatic wait_response(output logic timed_out, output int late);
      int waited;
      waited = 0;
      @(posedge clk);
      #1;  // Registered outputs are settled one ns after the edge
      while (!resp_valid && waited < RESP_TIMEOUT) begin
         @(posedge clk);
         #1;
         waited++;
      end
      timed_out = !resp_valid;
      late      = waited;
   endtask

   // ========================================
   // Stimulus and checks
   // ========================================
   initial begin
      int          fd;
      int          code;
      int          late;
      string       line;
      string       name;
      string       op;
      logic [31:0] v_in;
      logic [31:0] p_in;
      logic [31:0] e_hit;
      logic [31:0] e_way;
      logic [31:0] e_ptag;
      cache_cmd_t  e_cmd;
      logic        timed_out;

      errors    = 0;
      checks    = 0;
      late      = 0;
      timed_out = 1'b0;
      rst_n     = 1'b0;
      cmd_valid = 1'b0;
      cmd       = CMD_NOP;
      vadr      = '0;
      padr      = '0;

      repeat (3) @(posedge clk);  // Reset seen at three edges
      #1;
      rst_n = 1'b1;
      if (resp_valid !== 1'b0) begin
         $display("resp_valid is not low after reset");
         errors++;
      end

      fd = $fopen(DATA_FILE, "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file %s", DATA_FILE);
         errors++;
      end
      else begin
         while (!timed_out && $fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") continue;  // Blank or column notes
            code = $sscanf(line, "%s %s %h %h %h %h %h",
                           name, op, v_in, p_in, e_hit, e_way, e_ptag);
            if (code != 7) begin
               $display("Unreadable line in the stimulus file: %s", line);
               errors++;
               continue;
            end
            if (op == "L") e_cmd = CMD_LOOKUP;
            else if (op == "F") e_cmd = CMD_FILL;
            else if (op == "S") e_cmd = CMD_SNOOP;
            else begin
               $display("Unknown command letter %s in test %s", op, name);
               errors++;
               continue;
            end

            // Driven one ns after the edge and back to back with the previous command
            cmd_valid = 1'b1;
            cmd       = e_cmd;
            vadr      = v_in;
            padr      = p_in;

            wait_response(timed_out, late);
            if (timed_out) begin
               $display("No response to test %s within %0d cycles", name, RESP_TIMEOUT);
               errors++;
            end
            else begin
               checks++;
               if (late != 0) begin
                  $display("Response to test %s came %0d cycles late", name, late);
                  errors++;
               end
               if (resp_cmd !== e_cmd)
                  report_value(name, "cmd", 32'(e_cmd), 32'(resp_cmd));
               if (resp_hit !== e_hit[0])
                  report_value(name, "hit", e_hit, 32'(resp_hit));
               // Way and tag only mean something on a hit or a fill
               if (e_hit[0] || e_cmd == CMD_FILL) begin
                  if (resp_way !== e_way[1:0])
                     report_value(name, "way", e_way, 32'(resp_way));
                  if (resp_ptag !== e_ptag[TAG_W-1:0])
                     report_value(name, "ptag", e_ptag, 32'(resp_ptag));
               end
            end
         end
         $fclose(fd);
      end
      cmd_valid = 1'b0;
      cmd       = CMD_NOP;

      // The response drops once the commands stop and stays low while idle
      for (int i = 0; i < 2; i++) begin
         @(posedge clk);
         #1;
         if (resp_valid !== 1'b0) begin
            $display("resp_valid still high in idle cycle %0d without a command", i + 1);
            errors++;
         end
      end

      $display("Responses checked %0d, errors %0d", checks, errors);
      if (errors == 0 && !timed_out && checks > 0) begin
         $display("SIMULATION PASSED");
      end
      else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

//--- bench/cache_tag_testdata.txt
# name op vadr padr exp_hit exp_way exp_ptag, op is L lookup, F fill or S snoop
# Fields after op are hex; way and ptag are compared only on fills and hits
reset_miss_a     L 00000140 00000000 0 0 00000
reset_miss_b     L fffff000 00000000 0 0 00000
fill_way0        F 00022140 00a02140 0 0 00501
fill_way1        F 00044140 00a04140 0 1 00502
fill_way2        F 00066140 00a06140 0 2 00503
fill_way3        F 00088140 00a08140 0 3 00504
hit_way0         L 00022140 00000000 1 0 00501
hit_way1         L 00044140 00000000 1 1 00502
hit_way2         L 00066140 00000000 1 2 00503
hit_way3         L 00088140 00000000 1 3 00504
bank_bit_hit     L 00023140 00000000 1 0 00501
offset_hit       L 0002217f 00000000 1 0 00501
other_tag_miss   L 00132140 00000000 0 0 00000
touch_way2       L 00066140 00000000 1 2 00503
evict_fill       F 000aa140 00a0a140 0 1 00505
evicted_miss     L 00044140 00000000 0 0 00000
new_line_hit     L 000aa140 00000000 1 1 00505
snoop_hit        S 00000000 00a06140 1 2 00503
snooped_miss     L 00066140 00000000 0 0 00000
refill_freed     F 000cc140 00a0c140 0 2 00506
refill_hit       L 000cc140 00000000 1 2 00506
snoop_tag_miss   S 00000000 00eee140 0 0 00000
snoop_line_miss  S 00000000 00a02180 0 0 00000
b2b_fill         F 00246240 0f578240 0 0 07abc
b2b_lookup       L 00246240 00000000 1 0 07abc

//--- build.f
logic/cache_pkg.sv
logic/cache_tag.sv
logic/cache_valid.sv
logic/cache_hit.sv
logic/cache_lru.sv
logic/cache_tag_unit.sv
bench/cache_tag_properties.sv
bench/cache_tag_tb.sv

//--- logic/cache_hit.sv
// ========================================
// Tag compare for lookups and snoops, plus the one cycle response register
// Fills report the victim way and the physical tag written
// ========================================
`timescale 1ns/1ps

module cache_hit (
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  logic                                          cmd_valid,
   input  cache_pkg::cache_cmd_t                         cmd,
   input  cache_pkg::cache_tag_t                         lk_tag,     // Tag bits of vadr
   input  cache_pkg::cache_tag_t                         sn_tag,     // Tag bits of padr
   input  cache_pkg::cache_tag_t [cache_pkg::WAYS-1:0]   tag,        // Virtual tags
   input  cache_pkg::cache_tag_t [cache_pkg::WAYS-1:0]   ptag,       // Physical tags
   input  logic [cache_pkg::WAYS-1:0]                    valid,
   input  logic [cache_pkg::WAYS-1:0]                    svalid,
   input  cache_pkg::way_t                               victim_way,
   input  cache_pkg::cache_tag_t                         fill_ptag,
   output logic                                          comb_hit,   // Same cycle hit
   output cache_pkg::way_t                               comb_way,   // Lowest matching way
   output logic                                          resp_valid,
   output cache_pkg::cache_cmd_t                         resp_cmd,
   output logic                                          resp_hit,
   output cache_pkg::way_t                               resp_way,
   output cache_pkg::cache_tag_t                         resp_ptag
);

   import cache_pkg::*;

   logic [WAYS-1:0] lk_match;  // Valid virtual tag equals lk_tag
   logic [WAYS-1:0] sn_match;  // Valid physical tag equals sn_tag
   logic [WAYS-1:0] match;     // Selected by the command

   // ========================================
   // Comparators
   // ========================================
   always_comb begin
      for (int w = 0; w < WAYS; w++) begin
         lk_match[w] = valid[w] && (tag[w] == lk_tag);
         sn_match[w] = svalid[w] && (ptag[w] == sn_tag);
      end
   end

   // Fills and no-ops never report a hit
   assign match = (cmd == CMD_LOOKUP) ? lk_match :
                  (cmd == CMD_SNOOP)  ? sn_match : '0;

   // Scan downward so the lowest matching way ends up selected
   always_comb begin
      comb_way = '0;
      for (int w = WAYS - 1; w >= 0; w--) begin
         if (match[w]) begin
            comb_way = way_t'(w);
         end
      end
   end

   assign comb_hit = cmd_valid && (|match);

   // ========================================
   // Response register
   // ========================================
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         resp_valid <= 1'b0;
      end
      else begin
         resp_valid <= cmd_valid;  // Exactly one cycle behind the command
      end
   end

   always_ff @(posedge clk) begin
      if (cmd_valid) begin
         resp_cmd <= cmd;
         if (cmd == CMD_FILL) begin
            resp_hit  <= 1'b0;
            resp_way  <= victim_way;  // Way that was just written
            resp_ptag <= fill_ptag;
         end
         else begin
            resp_hit  <= comb_hit;
            resp_way  <= comb_way;
            resp_ptag <= ptag[comb_way];  // Translation of the hit way
         end
      end
   end

endmodule

//--- logic/cache_lru.sv
// ========================================
// Tree pseudo LRU state for each line and the fill victim choice
// Invalid ways are always used first
// ========================================
`timescale 1ns/1ps

module cache_lru (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         touch,       // Mark touch_way as most recent
   input  cache_pkg::way_t              touch_way,
   input  cache_pkg::index_t            touch_ndx,
   input  cache_pkg::index_t            ndx,         // Line the victim is chosen for
   input  logic [cache_pkg::WAYS-1:0]   valid,       // Valid bits at ndx
   output cache_pkg::way_t              victim_way
);

   import cache_pkg::*;

   // Bit 0 picks the pair, bit 1 picks within ways 0-1, bit 2 within ways 2-3
   logic [2:0] tree [LINES];
   logic [2:0] cur;       // Tree bits of the line at ndx
   way_t       lru_way;   // Choice made by the tree alone

   // ========================================
   // Touch update
   // ========================================
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < LINES; i++) begin
            tree[i] <= 3'b000;  // Every line starts out pointing at way 0
         end
      end
      else if (touch) begin
         if (!touch_way[1]) begin
            tree[touch_ndx][0] <= 1'b1;                    // Send the victim to ways 2-3
            tree[touch_ndx][1] <= (touch_way == way_t'(0)); // And away from this way
         end
         else begin
            tree[touch_ndx][0] <= 1'b0;                    // Send the victim to ways 0-1
            tree[touch_ndx][2] <= (touch_way == way_t'(2));
         end
      end
   end

   // ========================================
   // Victim selection
   // ========================================
   assign cur = tree[ndx];

   always_comb begin
      if (!cur[0]) begin
         lru_way = cur[1] ? way_t'(1) : way_t'(0);
      end
      else begin
         lru_way = cur[2] ? way_t'(3) : way_t'(2);
      end
   end

   // Lowest invalid way wins over the tree
   always_comb begin
      victim_way = lru_way;
      for (int w = WAYS - 1; w >= 0; w--) begin
         if (!valid[w]) begin
            victim_way = way_t'(w);
         end
      end
   end

endmodule

//--- logic/cache_pkg.sv
// ========================================
// Shared sizes, address fields and command codes for the cache tag unit
// Imported by every RTL block of the tag side
// ========================================

package cache_pkg;

   // ========================================
   // Geometry
   // ========================================
   localparam int LINES  = 64;              // Lines per way
   localparam int WAYS   = 4;               // Fixed by the three bit LRU tree
   localparam int LOBIT  = 6;               // Lowest index bit, 64 byte lines
   localparam int HIBIT  = 11;              // Highest index bit
   localparam int TAGBIT = 13;              // Bit 12 picks the odd or even bank outside
   localparam int ADDR_W = 32;              // Address width
   localparam int TAG_W  = ADDR_W - TAGBIT; // Tag width, 19 bits

   // ========================================
   // Types
   // ========================================
   typedef logic [ADDR_W-1:0] address_t;

   // Line index taken from address bits HIBIT down to LOBIT
   typedef logic [HIBIT-LOBIT:0] index_t;

   // Upper address bits above the bank select
   typedef logic [TAG_W-1:0] cache_tag_t;

   typedef logic [$clog2(WAYS)-1:0] way_t;

   // Command opcode carried with cmd_valid
   typedef enum logic [1:0] {
      CMD_NOP    = 2'd0,  // Accepted but does nothing except respond
      CMD_LOOKUP = 2'd1,  // Virtual tag compare
      CMD_FILL   = 2'd2,  // Write both tags into the victim way
      CMD_SNOOP  = 2'd3   // Physical tag compare and invalidate
   } cache_cmd_t;

endpackage

//--- logic/cache_tag.sv
// ========================================
// Virtual and physical tag storage for all four ways
// One synchronous write port, two zero latency read ports
// ========================================
`timescale 1ns/1ps

module cache_tag (
   input  logic                                          clk,
   input  logic                                          wr,       // Write both tags
   input  cache_pkg::way_t                               wr_way,   // Way receiving the write
   input  cache_pkg::index_t                             wr_ndx,   // Line receiving the write
   input  cache_pkg::cache_tag_t                         wr_vtag,
   input  cache_pkg::cache_tag_t                         wr_ptag,
   input  cache_pkg::index_t                             ndx,      // Virtual tag read index
   input  cache_pkg::index_t                             sndx,     // Physical tag read index
   output cache_pkg::cache_tag_t [cache_pkg::WAYS-1:0]   tag,      // Virtual tags at ndx
   output cache_pkg::cache_tag_t [cache_pkg::WAYS-1:0]   ptag      // Physical tags at sndx
);

   import cache_pkg::*;

   // ========================================
   // Storage
   // ========================================
   // Behaves like distributed RAM, so reads need no clock
   cache_tag_t vmem [WAYS][LINES];  // Virtual tags, used for CPU lookups
   cache_tag_t pmem [WAYS][LINES];  // Physical tags, used for snoops and translation

   // Both tags of a line are always written together by a fill
   always_ff @(posedge clk) begin
      if (wr) begin
         vmem[wr_way][wr_ndx] <= wr_vtag;
         pmem[wr_way][wr_ndx] <= wr_ptag;  // Same way and line as the virtual tag
      end
   end

   // ========================================
   // Read ports
   // ========================================
   // Every way is read in parallel so the comparators see all four at once
   always_comb begin
      for (int w = 0; w < WAYS; w++) begin
         tag[w] = vmem[w][ndx];
      end
   end

   // The physical port has its own index so a snoop can use padr directly
   always_comb begin
      for (int w = 0; w < WAYS; w++) begin
         ptag[w] = pmem[w][sndx];
      end
   end

   // A write lands at the clock edge
   // A read in the same cycle still returns the old contents
   // The command in the following cycle sees the new tag, which is all the
   // response timing needs

endmodule

//--- logic/cache_tag_unit.sv
// ========================================
// Tag side of one cache bank, four ways of 64 lines
// Takes lookup, fill and snoop strobes and answers one cycle later
// ========================================
`timescale 1ns/1ps

module cache_tag_unit (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    cmd_valid,   // One command per cycle, no stall
   input  cache_pkg::cache_cmd_t   cmd,
   input  cache_pkg::address_t     vadr,        // Lookup and fill address
   input  cache_pkg::address_t     padr,        // Fill data and snoop address
   output logic                    resp_valid,
   output cache_pkg::cache_cmd_t   resp_cmd,
   output logic                    resp_hit,
   output cache_pkg::way_t         resp_way,
   output cache_pkg::cache_tag_t   resp_ptag
);

   import cache_pkg::*;

   // ========================================
   // Address slicing and command decode
   // ========================================
   index_t     ndx;         // Line index from vadr
   index_t     sndx;        // Index for the physical tag and snoop valid reads
   cache_tag_t lk_tag;      // Virtual tag bits, bit 12 left out
   cache_tag_t sn_tag;      // Physical tag bits
   logic       is_lookup;
   logic       is_fill;
   logic       is_snoop;

   cache_tag_t [WAYS-1:0] tag;
   cache_tag_t [WAYS-1:0] ptag;
   logic [WAYS-1:0]       valid;
   logic [WAYS-1:0]       svalid;
   way_t                  victim_way;
   logic                  comb_hit;
   way_t                  comb_way;
   logic                  touch;
   way_t                  touch_way;

   assign ndx    = vadr[HIBIT:LOBIT];
   assign lk_tag = vadr[ADDR_W-1:TAGBIT];
   assign sn_tag = padr[ADDR_W-1:TAGBIT];

   assign is_lookup = cmd_valid && (cmd == CMD_LOOKUP);
   assign is_fill   = cmd_valid && (cmd == CMD_FILL);
   assign is_snoop  = cmd_valid && (cmd == CMD_SNOOP);

   // A lookup reads its translation from the vadr line, a snoop uses padr
   assign sndx = (cmd == CMD_SNOOP) ? padr[HIBIT:LOBIT] : ndx;

   // Fills and lookup hits both count as a use of the line
   assign touch     = is_fill || (is_lookup && comb_hit);
   assign touch_way = is_fill ? victim_way : comb_way;

   // ========================================
   // Blocks
   // ========================================
   cache_tag i_cache_tag (
      .clk     (clk),
      .wr      (is_fill),
      .wr_way  (victim_way),
      .wr_ndx  (ndx),
      .wr_vtag (lk_tag),
      .wr_ptag (sn_tag),
      .ndx     (ndx),
      .sndx    (sndx),
      .tag     (tag),
      .ptag    (ptag)
   );

   cache_valid i_cache_valid (
      .clk     (clk),
      .rst_n   (rst_n),
      .set     (is_fill),
      .set_way (victim_way),
      .set_ndx (ndx),
      .clr     (is_snoop && comb_hit),  // Only the matching way is dropped
      .clr_way (comb_way),
      .clr_ndx (sndx),
      .ndx     (ndx),
      .sndx    (sndx),
      .valid   (valid),
      .svalid  (svalid)
   );

   cache_hit i_cache_hit (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_valid  (cmd_valid),
      .cmd        (cmd),
      .lk_tag     (lk_tag),
      .sn_tag     (sn_tag),
      .tag        (tag),
      .ptag       (ptag),
      .valid      (valid),
      .svalid     (svalid),
      .victim_way (victim_way),
      .fill_ptag  (sn_tag),
      .comb_hit   (comb_hit),
      .comb_way   (comb_way),
      .resp_valid (resp_valid),
      .resp_cmd   (resp_cmd),
      .resp_hit   (resp_hit),
      .resp_way   (resp_way),
      .resp_ptag  (resp_ptag)
   );

   cache_lru i_cache_lru (
      .clk        (clk),
      .rst_n      (rst_n),
      .touch      (touch),
      .touch_way  (touch_way),
      .touch_ndx  (ndx),
      .ndx        (ndx),
      .valid      (valid),
      .victim_way (victim_way)
   );

endmodule

//--- logic/cache_valid.sv
// ========================================
// Valid bits for every line and way of the tag unit
// Set by fills, cleared by snoop hits and by reset
// ========================================
`timescale 1ns/1ps

module cache_valid (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         set,      // Fill marks a way valid
   input  cache_pkg::way_t              set_way,
   input  cache_pkg::index_t            set_ndx,
   input  logic                         clr,      // Snoop hit invalidates a way
   input  cache_pkg::way_t              clr_way,
   input  cache_pkg::index_t            clr_ndx,
   input  cache_pkg::index_t            ndx,      // Lookup and fill index
   input  cache_pkg::index_t            sndx,     // Snoop index
   output logic [cache_pkg::WAYS-1:0]   valid,
   output logic [cache_pkg::WAYS-1:0]   svalid
);

   import cache_pkg::*;

   logic [WAYS-1:0] vbits [LINES];  // One bit per way for each line

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < LINES; i++) begin
            vbits[i] <= '0;  // Masks whatever the tag RAM powers up with
         end
      end
      else begin
         if (set) begin
            vbits[set_ndx][set_way] <= 1'b1;
         end
         // The clear comes last, so a snoop beats a fill on the same bit
         if (clr) begin
            vbits[clr_ndx][clr_way] <= 1'b0;
         end
      end
   end

   // Combinational reads, in step with the tag RAM ports
   assign valid  = vbits[ndx];
   assign svalid = vbits[sndx];

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the cache tag testbench with Verilator, runs it and scans the log.
# Run from any directory; all paths are taken relative to the project root.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f build.f --top-module cache_tag_tb -o cache_tag_sim > build.log 2>&1 \
   || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/cache_tag_sim > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log

grep -q "SIMULATION FAILED" sim.log && { echo "Result: failures in sim.log"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "Result: run ended without a verdict"; exit 1; }
echo "Result: clean run"
